/* hdl/sya_geom_pkg.sv */
// Array geometry, datapath widths and the data types of the matrix engine
package sya_geom_pkg;

    // ==============================
    // Array geometry
    // ==============================
    localparam int NUM_ROW = 4;
    localparam int NUM_COL = 4;
    localparam int ROW_IDX_WIDTH = $clog2(NUM_ROW);

    // Steps to flush the skew after the last channel
    localparam int DRAIN_STEPS = NUM_ROW + NUM_COL - 1;
    localparam int DRAIN_CNT_WIDTH = $clog2(DRAIN_STEPS);

    // ==============================
    // Data widths and types
    // ==============================
    localparam int ACT_WIDTH = 8;
    localparam int WGT_WIDTH = 8;
    localparam int PSUM_WIDTH = 24;
    localparam int ADDR_WIDTH = 16;
    localparam int IDX_WIDTH = 8;
    localparam int SHIFT_WIDTH = 4;

    typedef logic signed [ACT_WIDTH-1:0] act_t;
    typedef logic signed [WGT_WIDTH-1:0] wgt_t;
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [IDX_WIDTH-1:0] idx_t;

    typedef act_t [NUM_ROW-1:0] act_vec_t;
    // One weight word, also one result row
    typedef wgt_t [NUM_COL-1:0] wgt_vec_t;
    typedef psum_t [NUM_ROW-1:0][NUM_COL-1:0] psum_grid_t;

endpackage

/* hdl/sya_cfg_pkg.sv */
// Configuration word layout, sequencer states and loop orders
package sya_cfg_pkg;

    import sya_geom_pkg::*;

    // ==============================
    // Configuration word fields
    // ==============================
    // Loop order sits in the lowest bit, ofm base at the top
    localparam int LOOP_ORD_BIT = 0;
    localparam int ZP_LSB = LOOP_ORD_BIT + 1;
    localparam int SHIFT_LSB = ZP_LSB + ACT_WIDTH;
    localparam int CHN_LSB = SHIFT_LSB + SHIFT_WIDTH;
    localparam int NUM_TIL_FLT_LSB = CHN_LSB + IDX_WIDTH;
    localparam int NUM_TIL_IFM_LSB = NUM_TIL_FLT_LSB + IDX_WIDTH;
    localparam int WGT_BASE_LSB = NUM_TIL_IFM_LSB + IDX_WIDTH;
    localparam int ACT_BASE_LSB = WGT_BASE_LSB + ADDR_WIDTH;
    localparam int OFM_BASE_LSB = ACT_BASE_LSB + ADDR_WIDTH;
    // 85 bits in all
    localparam int CFG_WIDTH = OFM_BASE_LSB + ADDR_WIDTH;

    // ==============================
    // Sequencer encodings
    // ==============================
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        DRAIN,
        WRITE
    } sya_state_e;

    // Filter tile index advancing fastest, or ifm tile index
    typedef enum logic {
        LOOP_FLT_INNER,
        LOOP_IFM_INNER
    } loop_order_e;

endpackage

/* hdl/sya_cfg_regs.sv */
// Configuration register block holding the captured fields of one configuration
module sya_cfg_regs
    import sya_geom_pkg::*;
    import sya_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [CFG_WIDTH-1:0]   cfg_info,
    input  logic                   cfg_take,
    output addr_t                  ofm_base,
    output addr_t                  act_base,
    output addr_t                  wgt_base,
    output idx_t                   num_til_ifm,
    output idx_t                   num_til_flt,
    output idx_t                   chn,
    output logic [SHIFT_WIDTH-1:0] shift,
    output act_t                   zp,
    output loop_order_e            loop_order
);

    idx_t chn_field;

    assign chn_field = cfg_info[CHN_LSB +: IDX_WIDTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_base <= '0;
            act_base <= '0;
            wgt_base <= '0;
            num_til_ifm <= idx_t'(1);
            num_til_flt <= idx_t'(1);
            chn <= idx_t'(1);
            shift <= '0;
            zp <= '0;
            loop_order <= LOOP_FLT_INNER;
        end else if (cfg_take) begin
            ofm_base <= cfg_info[OFM_BASE_LSB +: ADDR_WIDTH];
            act_base <= cfg_info[ACT_BASE_LSB +: ADDR_WIDTH];
            wgt_base <= cfg_info[WGT_BASE_LSB +: ADDR_WIDTH];
            num_til_ifm <= cfg_info[NUM_TIL_IFM_LSB +: IDX_WIDTH];
            num_til_flt <= cfg_info[NUM_TIL_FLT_LSB +: IDX_WIDTH];
            // Zero channels would never finish a tile
            chn <= (chn_field == '0) ? idx_t'(1) : chn_field;
            shift <= cfg_info[SHIFT_LSB +: SHIFT_WIDTH];
            zp <= cfg_info[ZP_LSB +: ACT_WIDTH];
            loop_order <= loop_order_e'(cfg_info[LOOP_ORD_BIT]);
        end
    end

endmodule

/* hdl/sya_loop_ctrl.sv */
// Sequencer FSM, tile and channel counters, read and write address generation
module sya_loop_ctrl
    import sya_geom_pkg::*;
    import sya_cfg_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_vld,
    output logic                     cfg_rdy,
    output logic                     cfg_take,
    input  addr_t                    ofm_base,
    input  addr_t                    act_base,
    input  addr_t                    wgt_base,
    input  idx_t                     num_til_ifm,
    input  idx_t                     num_til_flt,
    input  idx_t                     chn,
    input  loop_order_e              loop_order,
    output addr_t                    act_rd_addr,
    output logic                     act_rd_addr_vld,
    input  logic                     act_rd_addr_rdy,
    input  logic                     act_rd_dat_vld,
    output logic                     act_rd_dat_rdy,
    output addr_t                    wgt_rd_addr,
    output logic                     wgt_rd_addr_vld,
    input  logic                     wgt_rd_addr_rdy,
    input  logic                     wgt_rd_dat_vld,
    output logic                     wgt_rd_dat_rdy,
    output addr_t                    ofm_wr_addr,
    output logic                     ofm_wr_vld,
    input  logic                     ofm_wr_rdy,
    output logic                     step,
    output logic                     feed,
    output logic                     clear,
    output logic [ROW_IDX_WIDTH-1:0] row_sel
);

    sya_state_e state;
    sya_state_e state_nxt;
    idx_t req_cnt;
    idx_t acc_cnt;
    idx_t ifm_idx;
    idx_t flt_idx;
    addr_t tile_cnt;
    logic [DRAIN_CNT_WIDTH-1:0] drain_cnt;
    logic [ROW_IDX_WIDTH-1:0] row_cnt;
    logic req_pend;
    logic dat_rdy;
    logic last_acc;
    logic drain_end;
    logic tile_end;
    logic ifm_last;
    logic flt_last;

    // ==============================
    // Handshakes
    // ==============================
    assign cfg_rdy = (state == IDLE);
    assign cfg_take = cfg_vld & cfg_rdy;

    // Both address channels transfer together or not at all
    assign req_pend = (state == LOAD) && (req_cnt != chn);
    assign act_rd_addr_vld = req_pend & wgt_rd_addr_rdy;
    assign wgt_rd_addr_vld = req_pend & act_rd_addr_rdy;
    assign act_rd_addr = act_base + addr_t'(chn) * addr_t'(ifm_idx) + addr_t'(req_cnt);
    assign wgt_rd_addr = wgt_base + addr_t'(chn) * addr_t'(flt_idx) + addr_t'(req_cnt);

    assign dat_rdy = (state == LOAD) && (acc_cnt != chn);
    assign act_rd_dat_rdy = dat_rdy;
    assign wgt_rd_dat_rdy = dat_rdy;
    assign feed = dat_rdy & act_rd_dat_vld & wgt_rd_dat_vld;
    assign last_acc = feed && (acc_cnt == chn - 1'b1);

    assign step = feed | (state == DRAIN);
    assign drain_end = (state == DRAIN) && (drain_cnt == DRAIN_CNT_WIDTH'(DRAIN_STEPS - 1));

    assign ofm_wr_vld = (state == WRITE);
    assign ofm_wr_addr = ofm_base + addr_t'(tile_cnt * NUM_ROW) + addr_t'(row_cnt);
    assign row_sel = row_cnt;
    assign tile_end = ofm_wr_vld && ofm_wr_rdy && (row_cnt == ROW_IDX_WIDTH'(NUM_ROW - 1));
    assign clear = tile_end;

    assign ifm_last = (ifm_idx == num_til_ifm - 1'b1);
    assign flt_last = (flt_idx == num_til_flt - 1'b1);

    // ==============================
    // FSM
    // ==============================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    state_nxt = cfg_take ? LOAD : IDLE;
            LOAD:    state_nxt = last_acc ? DRAIN : LOAD;
            DRAIN:   state_nxt = drain_end ? WRITE : DRAIN;
            WRITE:   state_nxt = !tile_end ? WRITE : ((ifm_last & flt_last) ? IDLE : LOAD);
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            req_cnt <= '0;
            acc_cnt <= '0;
            drain_cnt <= '0;
            row_cnt <= '0;
        end else begin
            state <= state_nxt;
            // Every request is out before its data can return
            if (last_acc) begin
                req_cnt <= '0;
                acc_cnt <= '0;
            end else begin
                if (act_rd_addr_vld & act_rd_addr_rdy) begin
                    req_cnt <= req_cnt + 1'b1;
                end
                if (feed) begin
                    acc_cnt <= acc_cnt + 1'b1;
                end
            end
            if (state == DRAIN) begin
                drain_cnt <= drain_end ? '0 : drain_cnt + 1'b1;
            end
            if (ofm_wr_vld & ofm_wr_rdy) begin
                row_cnt <= tile_end ? '0 : row_cnt + 1'b1;
            end
        end
    end

    // Tile loop, inner index chosen by the loop order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifm_idx <= '0;
            flt_idx <= '0;
            tile_cnt <= '0;
        end else if (cfg_take) begin
            ifm_idx <= '0;
            flt_idx <= '0;
            tile_cnt <= '0;
        end else if (tile_end) begin
            tile_cnt <= tile_cnt + 1'b1;
            if (loop_order == LOOP_FLT_INNER || ifm_last) begin
                flt_idx <= flt_last ? '0 : flt_idx + 1'b1;
            end
            if (loop_order == LOOP_IFM_INNER || flt_last) begin
                ifm_idx <= ifm_last ? '0 : ifm_idx + 1'b1;
            end
        end
    end

endmodule

/* hdl/sya_pe_array.sv */
// Input skew lines and the output-stationary grid of multiply-accumulate cells
module sya_pe_array
    import sya_geom_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       step,
    input  logic       feed,
    input  logic       clear,
    input  act_vec_t   act_in,
    input  wgt_vec_t   wgt_in,
    output psum_grid_t psum
);

    act_vec_t act_src;
    wgt_vec_t wgt_src;
    // Operand seen by each cell, by row and by column
    act_t [NUM_COL-1:0] act_cell [NUM_ROW];
    wgt_t [NUM_ROW-1:0] wgt_cell [NUM_COL];

    // Idle steps push zeros through the skew
    assign act_src = feed ? act_in : '0;
    assign wgt_src = feed ? wgt_in : '0;

    // ==============================
    // Skew lines
    // ==============================
    // Row r lags by r steps, then moves east one cell per step
    for (genvar r = 0; r < NUM_ROW; r++) begin : g_act_line
        act_t [r+NUM_COL-1:0] line;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                line <= '0;
            end else if (step) begin
                line <= {line[r+NUM_COL-2:0], act_src[r]};
            end
        end

        assign act_cell[r] = line[r+NUM_COL-1:r];
    end

    // Column c lags by c steps, then moves south
    for (genvar c = 0; c < NUM_COL; c++) begin : g_wgt_line
        wgt_t [c+NUM_ROW-1:0] line;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                line <= '0;
            end else if (step) begin
                line <= {line[c+NUM_ROW-2:0], wgt_src[c]};
            end
        end

        assign wgt_cell[c] = line[c+NUM_ROW-1:c];
    end

    // ==============================
    // MAC grid
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum <= '0;
        end else if (clear) begin
            psum <= '0;
        end else if (step) begin
            for (int r = 0; r < NUM_ROW; r++) begin
                for (int c = 0; c < NUM_COL; c++) begin
                    psum[r][c] <= $signed(psum[r][c])
                                + $signed(act_cell[r][c]) * $signed(wgt_cell[c][r]);
                end
            end
        end
    end

endmodule

/* hdl/sya_ofm_quant.sv */
// Result row select with ReLU, right shift and zero-point requantization
module sya_ofm_quant
    import sya_geom_pkg::*;
(
    input  psum_grid_t               psum,
    input  logic [ROW_IDX_WIDTH-1:0] row_sel,
    input  logic [SHIFT_WIDTH-1:0]   shift,
    input  act_t                     zp,
    output wgt_vec_t                 ofm_wr_dat
);

    always_comb begin
        psum_t acc;
        psum_t scaled;
        for (int c = 0; c < NUM_COL; c++) begin
            acc = psum[row_sel][c];
            scaled = acc >>> shift;
            // Negative sums clip to zero, zero point wraps modulo 256
            if (acc[PSUM_WIDTH-1]) begin
                ofm_wr_dat[c] = '0;
            end else begin
                ofm_wr_dat[c] = scaled[ACT_WIDTH-1:0] + zp;
            end
        end
    end

endmodule

/* hdl/sya_top.sv */
// Top level of the matrix engine with register block, sequencer, array and requantizer
module sya_top
    import sya_geom_pkg::*;
    import sya_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cfg_vld,
    output logic                 cfg_rdy,
    input  logic [CFG_WIDTH-1:0] cfg_info,
    output addr_t                act_rd_addr,
    output logic                 act_rd_addr_vld,
    input  logic                 act_rd_addr_rdy,
    input  act_vec_t             act_rd_dat,
    input  logic                 act_rd_dat_vld,
    output logic                 act_rd_dat_rdy,
    output addr_t                wgt_rd_addr,
    output logic                 wgt_rd_addr_vld,
    input  logic                 wgt_rd_addr_rdy,
    input  wgt_vec_t             wgt_rd_dat,
    input  logic                 wgt_rd_dat_vld,
    output logic                 wgt_rd_dat_rdy,
    output wgt_vec_t             ofm_wr_dat,
    output addr_t                ofm_wr_addr,
    output logic                 ofm_wr_vld,
    input  logic                 ofm_wr_rdy
);

    // ==============================
    // Configuration fields
    // ==============================
    logic cfg_take;
    addr_t ofm_base;
    addr_t act_base;
    addr_t wgt_base;
    idx_t num_til_ifm;
    idx_t num_til_flt;
    idx_t chn;
    logic [SHIFT_WIDTH-1:0] shift;
    act_t zp;
    loop_order_e loop_order;

    // Array control and results
    logic step;
    logic feed;
    logic clear;
    logic [ROW_IDX_WIDTH-1:0] row_sel;
    psum_grid_t psum;

    sya_cfg_regs u_cfg_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_info    (cfg_info),
        .cfg_take    (cfg_take),
        .ofm_base    (ofm_base),
        .act_base    (act_base),
        .wgt_base    (wgt_base),
        .num_til_ifm (num_til_ifm),
        .num_til_flt (num_til_flt),
        .chn         (chn),
        .shift       (shift),
        .zp          (zp),
        .loop_order  (loop_order)
    );

    sya_loop_ctrl u_loop_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld         (cfg_vld),
        .cfg_rdy         (cfg_rdy),
        .cfg_take        (cfg_take),
        .ofm_base        (ofm_base),
        .act_base        (act_base),
        .wgt_base        (wgt_base),
        .num_til_ifm     (num_til_ifm),
        .num_til_flt     (num_til_flt),
        .chn             (chn),
        .loop_order      (loop_order),
        .act_rd_addr     (act_rd_addr),
        .act_rd_addr_vld (act_rd_addr_vld),
        .act_rd_addr_rdy (act_rd_addr_rdy),
        .act_rd_dat_vld  (act_rd_dat_vld),
        .act_rd_dat_rdy  (act_rd_dat_rdy),
        .wgt_rd_addr     (wgt_rd_addr),
        .wgt_rd_addr_vld (wgt_rd_addr_vld),
        .wgt_rd_addr_rdy (wgt_rd_addr_rdy),
        .wgt_rd_dat_vld  (wgt_rd_dat_vld),
        .wgt_rd_dat_rdy  (wgt_rd_dat_rdy),
        .ofm_wr_addr     (ofm_wr_addr),
        .ofm_wr_vld      (ofm_wr_vld),
        .ofm_wr_rdy      (ofm_wr_rdy),
        .step            (step),
        .feed            (feed),
        .clear           (clear),
        .row_sel         (row_sel)
    );

    sya_pe_array u_pe_array (
        .clk    (clk),
        .rst_n  (rst_n),
        .step   (step),
        .feed   (feed),
        .clear  (clear),
        .act_in (act_rd_dat),
        .wgt_in (wgt_rd_dat),
        .psum   (psum)
    );

    sya_ofm_quant u_ofm_quant (
        .psum       (psum),
        .row_sel    (row_sel),
        .shift      (shift),
        .zp         (zp),
        .ofm_wr_dat (ofm_wr_dat)
    );

endmodule

/* verif/sya_tb.sv */
// Testbench for the matrix engine with memory models, reference model, stimulus and checks
module sya_tb
    import sya_geom_pkg::*;
    import sya_cfg_pkg::*;
();

    localparam int WAIT_LIMIT = 5000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 cfg_vld;
    logic                 cfg_rdy;
    logic [CFG_WIDTH-1:0] cfg_info;
    addr_t                act_rd_addr;
    logic                 act_rd_addr_vld;
    logic                 act_rd_addr_rdy;
    act_vec_t             act_rd_dat;
    logic                 act_rd_dat_vld;
    logic                 act_rd_dat_rdy;
    addr_t                wgt_rd_addr;
    logic                 wgt_rd_addr_vld;
    logic                 wgt_rd_addr_rdy;
    wgt_vec_t             wgt_rd_dat;
    logic                 wgt_rd_dat_vld;
    logic                 wgt_rd_dat_rdy;
    wgt_vec_t             ofm_wr_dat;
    addr_t                ofm_wr_addr;
    logic                 ofm_wr_vld;
    logic                 ofm_wr_rdy;

    // Memory contents and expected traffic
    act_vec_t act_mem [0:65535];
    wgt_vec_t wgt_mem [0:65535];
    addr_t    exp_act_q[$];
    addr_t    exp_wgt_q[$];
    addr_t    exp_wr_addr_q[$];
    wgt_vec_t exp_wr_dat_q[$];
    // Outstanding read requests in issue order
    addr_t    req_act_q[$];
    addr_t    req_wgt_q[$];
    int       req_due_q[$];

    string cur_name;
    int    t_ofm;
    int    t_act;
    int    t_wgt;
    int    t_nti;
    int    t_ntf;
    int    t_chn;
    int    t_sh;
    int    t_zp;
    int    t_ord;
    int    t_writes;
    int    t_first;
    int    t_last;
    int    cyc;
    int    wr_cnt;
    addr_t first_wr;
    addr_t last_wr;
    logic  busy;

    sya_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld         (cfg_vld),
        .cfg_rdy         (cfg_rdy),
        .cfg_info        (cfg_info),
        .act_rd_addr     (act_rd_addr),
        .act_rd_addr_vld (act_rd_addr_vld),
        .act_rd_addr_rdy (act_rd_addr_rdy),
        .act_rd_dat      (act_rd_dat),
        .act_rd_dat_vld  (act_rd_dat_vld),
        .act_rd_dat_rdy  (act_rd_dat_rdy),
        .wgt_rd_addr     (wgt_rd_addr),
        .wgt_rd_addr_vld (wgt_rd_addr_vld),
        .wgt_rd_addr_rdy (wgt_rd_addr_rdy),
        .wgt_rd_dat      (wgt_rd_dat),
        .wgt_rd_dat_vld  (wgt_rd_dat_vld),
        .wgt_rd_dat_rdy  (wgt_rd_dat_rdy),
        .ofm_wr_dat      (ofm_wr_dat),
        .ofm_wr_addr     (ofm_wr_addr),
        .ofm_wr_vld      (ofm_wr_vld),
        .ofm_wr_rdy      (ofm_wr_rdy)
    );

    always #50 clk = ~clk;

    // ==============================
    // Error reporting
    // ==============================
    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_fault(string msg);
        $display("%s: %s", cur_name, msg);
        stop_run();
    endtask

    task automatic check_eq(string what, logic [31:0] exp, logic [31:0] act);
        assert (act == exp) else begin
            $display("[ERROR] %s %s: expected %h, got %h", cur_name, what, exp, act);
            stop_run();
        end
    endtask

    // ==============================
    // Reference model
    // ==============================
    task automatic fill_memories();
        for (int i = 0; i < 65536; i++) begin
            for (int r = 0; r < NUM_ROW; r++) begin
                act_mem[i][r] = act_t'($urandom_range(15, 0) - 8);
            end
            for (int c = 0; c < NUM_COL; c++) begin
                wgt_mem[i][c] = wgt_t'($urandom_range(15, 0) - 8);
            end
        end
    endtask

    function automatic logic [CFG_WIDTH-1:0] pack_cfg();
        logic [CFG_WIDTH-1:0] cfg;
        cfg = '0;
        cfg[OFM_BASE_LSB +: ADDR_WIDTH] = addr_t'(t_ofm);
        cfg[ACT_BASE_LSB +: ADDR_WIDTH] = addr_t'(t_act);
        cfg[WGT_BASE_LSB +: ADDR_WIDTH] = addr_t'(t_wgt);
        cfg[NUM_TIL_IFM_LSB +: IDX_WIDTH] = idx_t'(t_nti);
        cfg[NUM_TIL_FLT_LSB +: IDX_WIDTH] = idx_t'(t_ntf);
        cfg[CHN_LSB +: IDX_WIDTH] = idx_t'(t_chn);
        cfg[SHIFT_LSB +: SHIFT_WIDTH] = SHIFT_WIDTH'(t_sh);
        cfg[ZP_LSB +: ACT_WIDTH] = act_t'(t_zp);
        cfg[LOOP_ORD_BIT] = t_ord[0];
        return cfg;
    endfunction

    // Walk the tiles in loop order with one address pair per channel and one row per write
    task automatic build_expect();
        int chn;
        int tile;
        int ifm;
        int flt;
        int sum [NUM_ROW][NUM_COL];
        logic flt_inner;
        addr_t a;
        addr_t w;
        wgt_vec_t row;
        chn = (t_chn == 0) ? 1 : t_chn;
        flt_inner = (t_ord == int'(LOOP_FLT_INNER));
        tile = 0;
        for (int o = 0; o < (flt_inner ? t_nti : t_ntf); o++) begin
            for (int i = 0; i < (flt_inner ? t_ntf : t_nti); i++) begin
                ifm = flt_inner ? o : i;
                flt = flt_inner ? i : o;
                sum = '{default: 0};
                for (int k = 0; k < chn; k++) begin
                    a = addr_t'(t_act + chn * ifm + k);
                    w = addr_t'(t_wgt + chn * flt + k);
                    exp_act_q.push_back(a);
                    exp_wgt_q.push_back(w);
                    for (int r = 0; r < NUM_ROW; r++) begin
                        for (int c = 0; c < NUM_COL; c++) begin
                            sum[r][c] += int'(act_mem[a][r]) * int'(wgt_mem[w][c]);
                        end
                    end
                end
                for (int r = 0; r < NUM_ROW; r++) begin
                    for (int c = 0; c < NUM_COL; c++) begin
                        row[c] = (sum[r][c] < 0) ? '0 : wgt_t'((sum[r][c] >>> t_sh) + t_zp);
                    end
                    exp_wr_addr_q.push_back(addr_t'(t_ofm + NUM_ROW * tile + r));
                    exp_wr_dat_q.push_back(row);
                end
                tile++;
            end
        end
    endtask

    // ==============================
    // Memory model and monitor
    // ==============================
    always begin : mem_model
        logic addr_go;
        logic dat_go;
        addr_t a_req;
        addr_t w_req;
        @(negedge clk);
        if (busy) begin
            assert (!cfg_rdy) else report_fault("cfg_rdy high before the last result row");
        end
        addr_go = act_rd_addr_vld & act_rd_addr_rdy;
        assert (addr_go == (wgt_rd_addr_vld & wgt_rd_addr_rdy)) else
            report_fault("activation and weight requests did not transfer together");
        a_req = act_rd_addr;
        w_req = wgt_rd_addr;
        if (addr_go) begin
            assert (exp_act_q.size() > 0) else report_fault("read request after the last channel");
            check_eq("act_rd_addr", 32'(exp_act_q.pop_front()), 32'(a_req));
            check_eq("wgt_rd_addr", 32'(exp_wgt_q.pop_front()), 32'(w_req));
        end
        assert (act_rd_dat_rdy == wgt_rd_dat_rdy) else report_fault("data readies differ");
        dat_go = act_rd_dat_rdy & act_rd_dat_vld & wgt_rd_dat_vld;
        if (ofm_wr_vld & ofm_wr_rdy) begin
            assert (exp_wr_addr_q.size() > 0) else report_fault("write after the last result row");
            if (wr_cnt == 0) begin
                first_wr = ofm_wr_addr;
            end
            last_wr = ofm_wr_addr;
            wr_cnt++;
            check_eq("ofm_wr_addr", 32'(exp_wr_addr_q.pop_front()), 32'(ofm_wr_addr));
            check_eq("ofm_wr_dat", exp_wr_dat_q.pop_front(), ofm_wr_dat);
            if (exp_wr_addr_q.size() == 0) begin
                busy = 1'b0;
            end
        end
        if (cfg_vld & cfg_rdy) begin
            busy = 1'b1;
        end

        @(posedge clk);
        #1;
        cyc++;
        if (addr_go) begin
            req_act_q.push_back(a_req);
            req_wgt_q.push_back(w_req);
            req_due_q.push_back(cyc + int'($urandom_range(2, 0)));
        end
        if (dat_go) begin
            void'(req_act_q.pop_front());
            void'(req_wgt_q.pop_front());
            void'(req_due_q.pop_front());
        end
        // Head of line waits for its latency so data returns in order
        if (req_due_q.size() > 0 && req_due_q[0] <= cyc) begin
            act_rd_dat_vld = 1'b1;
            wgt_rd_dat_vld = 1'b1;
            act_rd_dat = act_mem[req_act_q[0]];
            wgt_rd_dat = wgt_mem[req_wgt_q[0]];
        end else begin
            act_rd_dat_vld = 1'b0;
            wgt_rd_dat_vld = 1'b0;
        end
        act_rd_addr_rdy = ($urandom_range(3, 0) != 0);
        wgt_rd_addr_rdy = ($urandom_range(3, 0) != 0);
        ofm_wr_rdy = ($urandom_range(2, 0) != 0);
    end

    // ==============================
    // Test sequence
    // ==============================
    task automatic run_test();
        int n;
        @(posedge clk);
        #1;
        wr_cnt = 0;
        build_expect();
        cfg_vld = 1'b1;
        cfg_info = pack_cfg();
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (cfg_rdy) break;
        end
        assert (n < WAIT_LIMIT) else report_fault("configuration was never accepted");
        @(posedge clk);
        #1;
        cfg_vld = 1'b0;
        // A second configuration while busy must be dropped
        @(posedge clk);
        #1;
        cfg_vld = 1'b1;
        cfg_info = ~cfg_info;
        @(posedge clk);
        #1;
        cfg_vld = 1'b0;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (cfg_rdy) break;
        end
        assert (n < WAIT_LIMIT) else report_fault("timed out waiting for cfg_rdy to return");
        check_eq("write count", t_writes, wr_cnt);
        check_eq("first write address", t_first, 32'(first_wr));
        check_eq("last write address", t_last, 32'(last_wr));
        check_eq("unissued read requests", 0, exp_act_q.size());
        check_eq("missing writes", 0, exp_wr_addr_q.size());
        $display("%s done, %0d rows written", cur_name, wr_cnt);
    endtask

    initial begin : main
        int fd;
        int n;
        int n_tests;
        string line;
        void'($urandom(32'h29f6_ed8b));
        rst_n = 1'b0;
        cfg_vld = 1'b0;
        cfg_info = '0;
        act_rd_addr_rdy = 1'b0;
        act_rd_dat = '0;
        act_rd_dat_vld = 1'b0;
        wgt_rd_addr_rdy = 1'b0;
        wgt_rd_dat = '0;
        wgt_rd_dat_vld = 1'b0;
        ofm_wr_rdy = 1'b0;
        busy = 1'b0;
        cyc = 0;
        wr_cnt = 0;
        first_wr = '0;
        last_wr = '0;
        n_tests = 0;
        cur_name = "reset";
        fill_memories();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);
        check_eq("cfg_rdy", 32'd1, 32'(cfg_rdy));
        check_eq("valids and data readies", 32'd0, 32'({act_rd_addr_vld, wgt_rd_addr_vld,
                 ofm_wr_vld, act_rd_dat_rdy, wgt_rd_dat_rdy}));

        fd = $fopen("verif/sya_stim.txt", "r");
        assert (fd != 0) else report_fault("cannot open verif/sya_stim.txt");
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 3 || line[0] == "#") continue;
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %d %h %h", cur_name,
                        t_ofm, t_act, t_wgt, t_nti, t_ntf, t_chn, t_sh, t_zp, t_ord,
                        t_writes, t_first, t_last);
            assert (n == 13) else report_fault("malformed line in the stimulus file");
            run_test();
            n_tests++;
        end
        $fclose(fd);

        if (n_tests > 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            report_fault("the stimulus file holds no tests");
        end
    end

endmodule

/* verif/sya_stim.txt */
# name ofm_base act_base wgt_base ifm_tiles flt_tiles chn shift zp loop_order writes first last
# all hex except writes (decimal); loop_order 0 is filter tile inner, 1 is ifm tile inner
single_tile 0100 0000 0800 01 01 08 2 10 0 4 0100 0103
zp_wrap     0200 0040 0900 01 01 06 0 f0 0 4 0200 0203
flt_inner   1000 0100 0a00 02 03 05 1 03 0 24 1000 1017
ifm_inner   2000 0200 0b00 03 02 04 3 80 1 24 2000 2017
chn_zero    3000 0300 0c00 01 02 00 0 00 1 8 3000 3007
long_chn    4000 1000 2000 02 02 14 4 7f 1 16 4000 400f
addr_wrap   fff8 fffc fff0 02 01 03 2 01 0 8 fff8 ffff
wide_shift  5000 0400 0d00 01 04 02 f 55 0 16 5000 500f
single_chn  6000 0500 0e00 03 03 01 1 fe 1 36 6000 6023

/* all.f */
hdl/sya_geom_pkg.sv
hdl/sya_cfg_pkg.sv
hdl/sya_cfg_regs.sv
hdl/sya_loop_ctrl.sv
hdl/sya_pe_array.sv
hdl/sya_ofm_quant.sv
hdl/sya_top.sv
verif/sya_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= sya_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
SIM_LOG   ?= sim.log
PASS_MSG  := TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail, the simulator status alone does not
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@grep -q "$(PASS_MSG)" $(SIM_LOG) || { echo "Simulation failed, see $(SIM_LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
